// File: Makefile
SRCS := $(shell grep -v '^+' files.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_top: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_top -f files.f -Mdir obj_dir -o Vtb_top

run: obj_dir/Vtb_top tb/exu_trace.txt
	./obj_dir/Vtb_top

clean:
	rm -rf obj_dir

// File: files.f
logic/exu_pkg.sv
logic/exu_if.sv
logic/idu.sv
logic/exu.sv
logic/wbu.sv
logic/exu_core_top.sv
tb/exu_asserts.sv
tb/tb_top.sv

// File: logic/exu.sv
`default_nettype none

module exu import exu_pkg::*; #(
	parameter int REG_AW = 4
) (
	input  logic clock,
	input  logic rst_n,
	dec_if.dst   dec,
	ex_if.src    ex
);

	logic            accept;
	logic [XLEN-1:0] lop;
	logic [XLEN-1:0] rop;
	logic [4:0]      shamt;
	alu_op_e         alu_op;
	logic [XLEN-1:0] alu_val;
	logic            src_eq;
	logic            src_lt;
	logic            src_ltu;
	logic            br_take;
	logic            jump_en;
	logic [XLEN-1:0] snpc;
	logic [XLEN-1:0] jump_addr_d;
	logic [3:0]      wmask_d;
	logic [XLEN-1:0] csr_wdata_d;

	assign accept = dec.valid & dec.ready;
	assign snpc   = dec.pc + 32'd4;

	assign lop = (dec.cls[CLS_AUIPC] | dec.cls[CLS_JAL] | dec.cls[CLS_BRANCH]) ? dec.pc :
			dec.cls[CLS_LUI] ? '0 : dec.src1;
	assign rop   = dec.cls[CLS_OP] ? dec.src2 : dec.imm;
	assign shamt = rop[4:0];

	always_comb begin
		alu_op = ALU_ADD; // address and target math
		if (dec.cls[CLS_OPIMM] | dec.cls[CLS_OP]) begin
			case (dec.funct3)
				3'b000: alu_op = (dec.cls[CLS_OP] & dec.funct7[5]) ? ALU_SUB : ALU_ADD;
				3'b001: alu_op = ALU_SLL;
				3'b010: alu_op = ALU_LESS;
				3'b011: alu_op = ALU_ULESS;
				3'b100: alu_op = ALU_XOR;
				3'b101: alu_op = dec.funct7[5] ? ALU_SRA : ALU_SRL;
				3'b110: alu_op = ALU_OR;
				default: alu_op = ALU_AND;
			endcase
		end
	end

	always_comb begin
		case (alu_op)
			ALU_SUB:   alu_val = lop - rop;
			ALU_AND:   alu_val = lop & rop;
			ALU_XOR:   alu_val = lop ^ rop;
			ALU_OR:    alu_val = lop | rop;
			ALU_SRL:   alu_val = lop >> shamt;
			ALU_SRA:   alu_val = $signed(lop) >>> shamt;
			ALU_SLL:   alu_val = lop << shamt;
			ALU_LESS:  alu_val = {{(XLEN-1){1'b0}}, $signed(lop) < $signed(rop)};
			ALU_ULESS: alu_val = {{(XLEN-1){1'b0}}, lop < rop};
			default:   alu_val = lop + rop;
		endcase
	end

	// branch compare always on the register operands
	assign src_eq  = dec.src1 == dec.src2;
	assign src_lt  = $signed(dec.src1) < $signed(dec.src2);
	assign src_ltu = dec.src1 < dec.src2;

	always_comb begin
		case (dec.funct3)
			3'b000: br_take = src_eq;
			3'b001: br_take = ~src_eq;
			3'b100: br_take = src_lt;
			3'b101: br_take = ~src_lt;
			3'b110: br_take = src_ltu;
			3'b111: br_take = ~src_ltu;
			default: br_take = 1'b0;
		endcase
	end

	assign jump_en     = dec.cls[CLS_JAL] | dec.cls[CLS_JALR] | (dec.cls[CLS_BRANCH] & br_take);
	assign jump_addr_d = jump_en ? alu_val : snpc;

	assign wmask_d = (dec.funct3[1:0] == 2'b00) ? 4'h1 :
			(dec.funct3[1:0] == 2'b01) ? 4'h3 :
			(dec.funct3[1:0] == 2'b10) ? 4'hf : 4'h0;

	assign csr_wdata_d = (dec.funct3 == 3'b001) ? dec.src1 :
			(dec.funct3 == 3'b010) ? (dec.src1 | dec.csr_val) : '0;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			dec.ready     <= 1'b1;
			ex.valid      <= 1'b0;
			ex.jump_wrong <= 1'b0;
		end else begin
			dec.ready <= dec.ready ? ~dec.valid : (ex.valid & ex.ready);
			ex.valid  <= ex.valid ? ~ex.ready : accept;
			if (accept)
				ex.jump_wrong <= jump_addr_d != snpc;
			else if (ex.valid & ex.ready)
				ex.jump_wrong <= 1'b0; // dropped once wbu has it
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			ex.rd         <= dec.rd[REG_AW-1:0];
			ex.pc         <= dec.pc;
			ex.val        <= alu_val;
			ex.csr_val    <= dec.csr_val;
			ex.funct3     <= dec.funct3;
			ex.reg_wen    <= dec.reg_wen;
			ex.lsu_ren    <= dec.cls[CLS_LOAD];
			ex.lsu_wen    <= dec.cls[CLS_STORE];
			ex.wmask      <= wmask_d;
			ex.lsu_data   <= dec.src2;
			ex.csr_enable <= dec.cls[CLS_CSR] & (dec.funct3 != 3'b000);
			ex.csr_wdata  <= csr_wdata_d;
			ex.jal_enable <= dec.cls[CLS_JAL] | dec.cls[CLS_JALR];
			ex.jump_addr  <= jump_addr_d;
		end
	end

endmodule

`default_nettype wire

// File: logic/exu_core_top.sv
`default_nettype none

module exu_core_top import exu_pkg::*; #(
	parameter int REG_AW = 4 // 5 for rv32i
) (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  logic [XLEN-1:0]   inst,
	input  logic [XLEN-1:0]   pc,
	input  logic [XLEN-1:0]   src1,
	input  logic [XLEN-1:0]   src2,
	input  logic [XLEN-1:0]   csr_val,
	output logic              out_valid,
	input  logic              out_ready,
	output logic [REG_AW-1:0] out_rd,
	output logic [XLEN-1:0]   out_wdata,
	output logic              out_reg_wen,
	output logic              out_csr_wen,
	output logic [XLEN-1:0]   out_csr_wdata,
	output logic              out_redirect,
	output logic [XLEN-1:0]   out_redirect_pc,
	output logic              out_mem_ren,
	output logic              out_mem_wen,
	output logic [XLEN-1:0]   out_mem_addr,
	output logic [XLEN-1:0]   out_mem_wdata,
	output logic [3:0]        out_mem_wmask
);

	dec_if #(.REG_AW(REG_AW)) dec_bus ();
	ex_if  #(.REG_AW(REG_AW)) ex_bus ();

	idu #(.REG_AW(REG_AW)) u_idu (
		.clock    (clock),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.inst     (inst),
		.pc       (pc),
		.src1     (src1),
		.src2     (src2),
		.csr_val  (csr_val),
		.dec      (dec_bus.src)
	);

	exu #(.REG_AW(REG_AW)) u_exu (
		.clock (clock),
		.rst_n (rst_n),
		.dec   (dec_bus.dst),
		.ex    (ex_bus.src)
	);

	wbu #(.REG_AW(REG_AW)) u_wbu (
		.clock           (clock),
		.rst_n           (rst_n),
		.ex              (ex_bus.dst),
		.out_valid       (out_valid),
		.out_ready       (out_ready),
		.out_rd          (out_rd),
		.out_wdata       (out_wdata),
		.out_reg_wen     (out_reg_wen),
		.out_csr_wen     (out_csr_wen),
		.out_csr_wdata   (out_csr_wdata),
		.out_redirect    (out_redirect),
		.out_redirect_pc (out_redirect_pc),
		.out_mem_ren     (out_mem_ren),
		.out_mem_wen     (out_mem_wen),
		.out_mem_addr    (out_mem_addr),
		.out_mem_wdata   (out_mem_wdata),
		.out_mem_wmask   (out_mem_wmask)
	);

endmodule

`default_nettype wire

// File: logic/exu_if.sv
`default_nettype none

interface dec_if import exu_pkg::*; #(
	parameter int REG_AW = 4
) ();
	logic                 valid;
	logic                 ready;
	logic [NUM_CLASS-1:0] cls; // one-hot, indexed by inst_class_e
	logic [REG_AW-1:0]    rd;
	logic [2:0]           funct3;
	logic [6:0]           funct7;
	logic [XLEN-1:0]      imm;
	logic [XLEN-1:0]      pc;
	logic [XLEN-1:0]      src1;
	logic [XLEN-1:0]      src2;
	logic [XLEN-1:0]      csr_val;
	logic                 reg_wen;

	modport src(
		output valid, cls, rd, funct3, funct7, imm, pc, src1, src2, csr_val, reg_wen,
		input  ready
	);
	modport dst(
		input  valid, cls, rd, funct3, funct7, imm, pc, src1, src2, csr_val, reg_wen,
		output ready
	);
endinterface

interface ex_if import exu_pkg::*; #(
	parameter int REG_AW = 4
) ();
	logic              valid;
	logic              ready;
	logic [REG_AW-1:0] rd;
	logic [XLEN-1:0]   pc;
	logic [XLEN-1:0]   val; // alu result, also the lsu address
	logic [XLEN-1:0]   csr_val;
	logic [2:0]        funct3;
	logic              reg_wen;
	logic              lsu_ren;
	logic              lsu_wen;
	logic [3:0]        wmask;
	logic [XLEN-1:0]   lsu_data;
	logic              csr_enable;
	logic [XLEN-1:0]   csr_wdata;
	logic              jal_enable;
	logic [XLEN-1:0]   jump_addr;
	logic              jump_wrong;

	modport src(
		output valid, rd, pc, val, csr_val, funct3, reg_wen, lsu_ren, lsu_wen, wmask,
		       lsu_data, csr_enable, csr_wdata, jal_enable, jump_addr, jump_wrong,
		input  ready
	);
	modport dst(
		input  valid, rd, pc, val, csr_val, funct3, reg_wen, lsu_ren, lsu_wen, wmask,
		       lsu_data, csr_enable, csr_wdata, jal_enable, jump_addr, jump_wrong,
		output ready
	);
endinterface

`default_nettype wire

// File: logic/exu_pkg.sv
`default_nettype none

package exu_pkg;

	localparam int XLEN      = 32;
	localparam int NUM_CLASS = 10;

	// bit positions in the one-hot class vector
	typedef enum logic [3:0] {
		CLS_LUI,
		CLS_AUIPC,
		CLS_JAL,
		CLS_JALR,
		CLS_BRANCH,
		CLS_LOAD,
		CLS_STORE,
		CLS_OPIMM,
		CLS_OP,
		CLS_CSR
	} inst_class_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_XOR,
		ALU_OR,
		ALU_SRL,
		ALU_SRA,
		ALU_SLL,
		ALU_LESS,
		ALU_ULESS
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// same 32 bits, six views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_word_u;

endpackage

`default_nettype wire

// File: logic/idu.sv
`default_nettype none

module idu import exu_pkg::*; #(
	parameter int REG_AW = 4
) (
	input  logic            clock,
	input  logic            rst_n,
	input  logic            in_valid,
	output logic            in_ready,
	input  inst_word_u      inst,
	input  logic [XLEN-1:0] pc,
	input  logic [XLEN-1:0] src1,
	input  logic [XLEN-1:0] src2,
	input  logic [XLEN-1:0] csr_val,
	dec_if.src              dec
);

	logic                 accept;
	logic [NUM_CLASS-1:0] cls_d;
	logic [XLEN-1:0]      imm_d;
	logic [XLEN-1:0]      imm_i;
	logic [XLEN-1:0]      imm_s;
	logic [XLEN-1:0]      imm_b;
	logic [XLEN-1:0]      imm_u;
	logic [XLEN-1:0]      imm_j;

	assign accept = in_valid & in_ready;

	assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
	assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
	assign imm_b = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
			inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
	assign imm_u = {inst.u_fmt.imm, 12'b0};
	assign imm_j = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
			inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};

	always_comb begin
		cls_d = '0;
		imm_d = '0;
		case (inst.r_fmt.opcode)
			7'b0110111: begin cls_d[CLS_LUI] = 1'b1; imm_d = imm_u; end
			7'b0010111: begin cls_d[CLS_AUIPC] = 1'b1; imm_d = imm_u; end
			7'b1101111: begin cls_d[CLS_JAL] = 1'b1; imm_d = imm_j; end
			7'b1100111: begin cls_d[CLS_JALR] = 1'b1; imm_d = imm_i; end
			7'b1100011: begin cls_d[CLS_BRANCH] = 1'b1; imm_d = imm_b; end
			7'b0000011: begin cls_d[CLS_LOAD] = 1'b1; imm_d = imm_i; end
			7'b0100011: begin cls_d[CLS_STORE] = 1'b1; imm_d = imm_s; end
			7'b0010011: begin cls_d[CLS_OPIMM] = 1'b1; imm_d = imm_i; end
			7'b0110011: cls_d[CLS_OP] = 1'b1; // no immediate
			7'b1110011: begin cls_d[CLS_CSR] = 1'b1; imm_d = imm_i; end // csr address
			default: ;
		endcase
	end

	// ready and valid swap on every accept at either side
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			in_ready  <= 1'b1;
			dec.valid <= 1'b0;
		end else begin
			in_ready  <= in_ready ? ~in_valid : (dec.valid & dec.ready);
			dec.valid <= dec.valid ? ~dec.ready : accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			dec.cls     <= cls_d;
			dec.rd      <= inst.r_fmt.rd[REG_AW-1:0];
			dec.funct3  <= inst.r_fmt.funct3;
			dec.funct7  <= inst.r_fmt.funct7;
			dec.imm     <= imm_d;
			dec.pc      <= pc;
			dec.src1    <= src1;
			dec.src2    <= src2;
			dec.csr_val <= csr_val;
			dec.reg_wen <= (|cls_d) & ~cls_d[CLS_BRANCH] & ~cls_d[CLS_STORE];
		end
	end

endmodule

`default_nettype wire

// File: logic/wbu.sv
`default_nettype none

module wbu import exu_pkg::*; #(
	parameter int REG_AW = 4
) (
	input  logic              clock,
	input  logic              rst_n,
	ex_if.dst                 ex,
	output logic              out_valid,
	input  logic              out_ready,
	output logic [REG_AW-1:0] out_rd,
	output logic [XLEN-1:0]   out_wdata,
	output logic              out_reg_wen,
	output logic              out_csr_wen,
	output logic [XLEN-1:0]   out_csr_wdata,
	output logic              out_redirect,
	output logic [XLEN-1:0]   out_redirect_pc,
	output logic              out_mem_ren,
	output logic              out_mem_wen,
	output logic [XLEN-1:0]   out_mem_addr,
	output logic [XLEN-1:0]   out_mem_wdata,
	output logic [3:0]        out_mem_wmask
);

	logic            accept;
	logic            csr_op_ok;
	logic [XLEN-1:0] wdata_d;

	assign accept = ex.valid & ex.ready;

	// only csrrw and csrrs write the csr
	assign csr_op_ok = (ex.funct3 == 3'b001) | (ex.funct3 == 3'b010);

	assign wdata_d = ex.jal_enable ? ex.pc + 32'd4 :
			ex.csr_enable ? ex.csr_val :
			ex.lsu_ren ? '0 : ex.val; // load data comes from memory

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ex.ready     <= 1'b1;
			out_valid    <= 1'b0;
			out_reg_wen  <= 1'b0;
			out_csr_wen  <= 1'b0;
			out_redirect <= 1'b0;
			out_mem_ren  <= 1'b0;
			out_mem_wen  <= 1'b0;
		end else begin
			ex.ready  <= ex.ready ? ~ex.valid : (out_valid & out_ready);
			out_valid <= out_valid ? ~out_ready : accept;
			if (accept) begin
				out_reg_wen  <= ex.reg_wen;
				out_csr_wen  <= ex.csr_enable & csr_op_ok;
				out_redirect <= ex.jump_wrong;
				out_mem_ren  <= ex.lsu_ren;
				out_mem_wen  <= ex.lsu_wen;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			out_rd          <= ex.rd;
			out_wdata       <= wdata_d;
			out_csr_wdata   <= ex.csr_wdata;
			out_redirect_pc <= ex.jump_addr;
			out_mem_addr    <= ex.val;
			out_mem_wdata   <= ex.lsu_data;
			out_mem_wmask   <= ex.wmask;
		end
	end

endmodule

`default_nettype wire

// File: tb/exu_asserts.sv
`default_nettype none

module exu_asserts import exu_pkg::*; #(
	parameter int REG_AW = 4
) (
	input logic              clock,
	input logic              rst_n,
	input logic              in_ready,
	input logic              out_valid,
	input logic              out_ready,
	input logic [REG_AW-1:0] out_rd,
	input logic [XLEN-1:0]   out_val,
	input logic [XLEN-1:0]   out_jump_addr,
	input logic [XLEN-1:0]   out_lsu_data
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [REG_AW+3*XLEN-1:0] held;
	int                       fail_count = 0;

	assign held = {out_rd, out_val, out_jump_addr, out_lsu_data};

	a_hold: assert property (@(posedge clock) disable iff (!rst_n)
		(out_valid && !out_ready) |=> (out_valid && $stable(held)))
		else begin
			$error("exu output dropped or changed before it was taken");
			fail_count++;
		end

	// stage is either empty or full
	a_excl: assert property (@(posedge clock) disable iff (!rst_n)
		!(in_ready && out_valid))
		else begin
			$error("exu ready and output valid high together");
			fail_count++;
		end

	a_reset: assert property (@(posedge clock) $rose(rst_n) |-> (in_ready && !out_valid))
		else begin
			$error("exu not empty when reset was released");
			fail_count++;
		end

endmodule

bind exu exu_asserts #(.REG_AW(REG_AW)) asserts0 (
	.clock         (clock),
	.rst_n         (rst_n),
	.in_ready      (dec.ready),
	.out_valid     (ex.valid),
	.out_ready     (ex.ready),
	.out_rd        (ex.rd),
	.out_val       (ex.val),
	.out_jump_addr (ex.jump_addr),
	.out_lsu_data  (ex.lsu_data)
);

`default_nettype wire

// File: tb/exu_trace.txt
# inst pc src1 src2 csr_val | rd wdata reg_wen csr_wen csr_wdata redirect redirect_pc
# mem_ren mem_wen addr mem_wdata wmask (all hex, fields without meaning are zero)
FFB08193 00001000 00000010 00000000 00000000 3 0000000B 1 0 00000000 0 00000000 0 0 00000000 00000000 0
0010A213 00001004 FFFFFFFF 00000000 00000000 4 00000001 1 0 00000000 0 00000000 0 0 00000000 00000000 0
0010B293 00001008 FFFFFFFF 00000000 00000000 5 00000000 1 0 00000000 0 00000000 0 0 00000000 00000000 0
4040D313 0000100C 80000000 00000000 00000000 6 F8000000 1 0 00000000 0 00000000 0 0 00000000 00000000 0
402083B3 00001010 00000005 00000008 00000000 7 FFFFFFFD 1 0 00000000 0 00000000 0 0 00000000 00000000 0
00209433 00001014 00000003 00000024 00000000 8 00000030 1 0 00000000 0 00000000 0 0 00000000 00000000 0
4020D4B3 00001018 80000010 00000021 00000000 9 C0000008 1 0 00000000 0 00000000 0 0 00000000 00000000 0
0020A533 0000101C FFFFFFFE 00000001 00000000 a 00000001 1 0 00000000 0 00000000 0 0 00000000 00000000 0
0020B5B3 00001020 FFFFFFFE 00000001 00000000 b 00000000 1 0 00000000 0 00000000 0 0 00000000 00000000 0
0020C633 00001024 F0F0F0F0 0FF00FF0 00000000 c FF00FF00 1 0 00000000 0 00000000 0 0 00000000 00000000 0
123456B7 00001028 00000000 00000000 00000000 d 12345000 1 0 00000000 0 00000000 0 0 00000000 00000000 0
00001717 00002000 00000000 00000000 00000000 e 00003000 1 0 00000000 0 00000000 0 0 00000000 00000000 0
00208863 00001000 00000007 00000007 00000000 0 00000000 0 0 00000000 1 00001010 0 0 00000000 00000000 0
00209863 00001000 00000007 00000007 00000000 0 00000000 0 0 00000000 0 00000000 0 0 00000000 00000000 0
FE20CCE3 00001020 FFFFFFF0 00000001 00000000 0 00000000 0 0 00000000 1 00001018 0 0 00000000 00000000 0
0020F863 00001030 00000001 FFFFFFFF 00000000 0 00000000 0 0 00000000 0 00000000 0 0 00000000 00000000 0
100000EF 00001000 00000000 00000000 00000000 1 00001004 1 0 00000000 1 00001100 0 0 00000000 00000000 0
0040016F 00002000 00000000 00000000 00000000 2 00002004 1 0 00000000 0 00000000 0 0 00000000 00000000 0
008082E7 00001000 00004000 00000000 00000000 5 00001004 1 0 00000000 1 00004008 0 0 00000000 00000000 0
0020A623 00001040 00000100 DEADBEEF 00000000 0 00000000 0 0 00000000 0 00000000 0 1 0000010C DEADBEEF f
FFC0A303 00001044 00000200 00000000 00000000 6 00000000 1 0 00000000 0 00000000 1 0 000001FC 00000000 0
300093F3 00001048 00001888 00000000 00000008 7 00000008 1 1 00001888 0 00000000 0 0 00000000 00000000 0
3000A473 0000104C 0000000F 00000000 000000F0 8 000000F0 1 1 000000FF 0 00000000 0 0 00000000 00000000 0

// File: tb/tb_top.sv
`default_nettype none

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int REG_AW = 4;

	typedef struct packed {
		logic [31:0] inst;
		logic [31:0] pc;
		logic [31:0] src1;
		logic [31:0] src2;
		logic [31:0] csr_val;
		logic [31:0] rd;
		logic [31:0] wdata;
		logic [31:0] reg_wen;
		logic [31:0] csr_wen;
		logic [31:0] csr_wdata;
		logic [31:0] redirect;
		logic [31:0] redirect_pc;
		logic [31:0] mem_ren;
		logic [31:0] mem_wen;
		logic [31:0] addr;
		logic [31:0] mem_wdata;
		logic [31:0] wmask;
	} trace_rec_t;

	logic              clock;
	logic              rst_n;
	logic              in_valid;
	logic              in_ready;
	logic [31:0]       inst;
	logic [31:0]       pc;
	logic [31:0]       src1;
	logic [31:0]       src2;
	logic [31:0]       csr_val;
	logic              out_valid;
	logic              out_ready;
	logic [REG_AW-1:0] out_rd;
	logic [31:0]       out_wdata;
	logic              out_reg_wen;
	logic              out_csr_wen;
	logic [31:0]       out_csr_wdata;
	logic              out_redirect;
	logic [31:0]       out_redirect_pc;
	logic              out_mem_ren;
	logic              out_mem_wen;
	logic [31:0]       out_mem_addr;
	logic [31:0]       out_mem_wdata;
	logic [3:0]        out_mem_wmask;

	trace_rec_t  recs[$];
	int          out_count = 0;
	int          error_count = 0;
	logic [31:0] lfsr;

	exu_core_top #(.REG_AW(REG_AW)) dut0 (
		.clock           (clock),
		.rst_n           (rst_n),
		.in_valid        (in_valid),
		.in_ready        (in_ready),
		.inst            (inst),
		.pc              (pc),
		.src1            (src1),
		.src2            (src2),
		.csr_val         (csr_val),
		.out_valid       (out_valid),
		.out_ready       (out_ready),
		.out_rd          (out_rd),
		.out_wdata       (out_wdata),
		.out_reg_wen     (out_reg_wen),
		.out_csr_wen     (out_csr_wen),
		.out_csr_wdata   (out_csr_wdata),
		.out_redirect    (out_redirect),
		.out_redirect_pc (out_redirect_pc),
		.out_mem_ren     (out_mem_ren),
		.out_mem_wen     (out_mem_wen),
		.out_mem_addr    (out_mem_addr),
		.out_mem_wdata   (out_mem_wdata),
		.out_mem_wmask   (out_mem_wmask)
	);

	always #50 clock = ~clock;

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			error_count++;
			$display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, expected);
			abort_run("an output of the DUT did not match the trace");
		end
	endtask

	task automatic load_trace();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f [17];
		trace_rec_t  r;
		fd = $fopen("tb/exu_trace.txt", "r");
		if (fd == 0)
			abort_run("could not open the trace file tb/exu_trace.txt");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
				if (n != 17)
					abort_run("a trace line does not hold 17 columns");
				r = {f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
					f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]};
				recs.push_back(r);
			end
		end
		$fclose(fd);
		if (recs.size() == 0)
			abort_run("the trace file holds no records");
	endtask

	task automatic check_idle(input string when);
		check_value({when, " in_ready"}, 32'(in_ready), 32'd1);
		check_value({when, " out_valid"}, 32'(out_valid), 32'd0);
		check_value({when, " out_reg_wen"}, 32'(out_reg_wen), 32'd0);
		check_value({when, " out_csr_wen"}, 32'(out_csr_wen), 32'd0);
		check_value({when, " out_redirect"}, 32'(out_redirect), 32'd0);
		check_value({when, " out_mem_ren"}, 32'(out_mem_ren), 32'd0);
		check_value({when, " out_mem_wen"}, 32'(out_mem_wen), 32'd0);
	endtask

	task automatic send_record(input trace_rec_t r);
		int   waited;
		logic taken;
		inst     = r.inst;
		pc       = r.pc;
		src1     = r.src1;
		src2     = r.src2;
		csr_val  = r.csr_val;
		in_valid = 1'b1;
		waited   = 0;
		taken    = 1'b0;
		while (!taken) begin
			@(posedge clock);
			taken = in_ready;
			waited++;
			if (!taken && waited > 50)
				abort_run("timeout: the DUT did not accept an input record");
		end
		#2;
		in_valid = 1'b0;
	endtask

	// fields that carry no meaning for a record are skipped
	task automatic compare_output(input int idx);
		trace_rec_t e;
		string      tag;
		e   = recs[idx];
		tag = $sformatf("record %0d", idx);
		check_value({tag, " reg_wen"}, 32'(out_reg_wen), e.reg_wen);
		check_value({tag, " csr_wen"}, 32'(out_csr_wen), e.csr_wen);
		check_value({tag, " redirect"}, 32'(out_redirect), e.redirect);
		check_value({tag, " mem_ren"}, 32'(out_mem_ren), e.mem_ren);
		check_value({tag, " mem_wen"}, 32'(out_mem_wen), e.mem_wen);
		if (e.reg_wen != 0) begin
			check_value({tag, " rd"}, 32'(out_rd), e.rd);
			check_value({tag, " wdata"}, out_wdata, e.wdata);
		end
		if (e.csr_wen != 0)
			check_value({tag, " csr_wdata"}, out_csr_wdata, e.csr_wdata);
		if (e.redirect != 0)
			check_value({tag, " redirect_pc"}, out_redirect_pc, e.redirect_pc);
		if (e.mem_ren != 0 || e.mem_wen != 0)
			check_value({tag, " mem_addr"}, out_mem_addr, e.addr);
		if (e.mem_wen != 0) begin
			check_value({tag, " mem_wdata"}, out_mem_wdata, e.mem_wdata);
			check_value({tag, " mem_wmask"}, 32'(out_mem_wmask), e.wmask);
		end
	endtask

	// random back-pressure, one lfsr bit per cycle
	always @(posedge clock) begin
		#2;
		lfsr = lfsr_step(lfsr);
		out_ready = lfsr[0];
	end

	always @(posedge clock) begin
		if (rst_n && out_valid && out_ready) begin
			if (out_count >= recs.size())
				abort_run("the DUT produced more outputs than the trace holds");
			compare_output(out_count);
			out_count++;
		end
	end

	initial begin
		int waited;
		clock     = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		inst      = '0;
		pc        = '0;
		src1      = '0;
		src2      = '0;
		csr_val   = '0;
		out_ready = 1'b0;
		lfsr      = 32'h3b5e9cd7;
		load_trace();

		repeat (3) @(posedge clock);
		#2;
		check_idle("during reset");
		repeat (2) @(posedge clock);
		#2;
		rst_n = 1'b1;
		@(posedge clock);
		#2;
		check_idle("after reset");

		foreach (recs[i])
			send_record(recs[i]);

		waited = 0;
		while (out_count < recs.size()) begin
			@(posedge clock);
			waited++;
			if (waited > 400)
				abort_run("timeout: not every trace record came out of the DUT");
		end
		repeat (10) @(posedge clock); // room for a stray extra output

		if (error_count == 0 && dut0.u_exu.asserts0.fail_count == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			abort_run("checks failed during the run");
		end
	end

endmodule

`default_nettype wire
